// ==== Bender.yml ====
package:
  name: data_mem_port

sources:
  - rtl/mem_bus_pkg.sv
  - rtl/grant_timing_pkg.sv
  - rtl/grant_timer.sv
  - rtl/bram_store.sv
  - rtl/response_stage.sv
  - rtl/data_mem_port.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/data_mem_port_tb.sv

// ==== data_mem_port.f ====
+incdir+test
rtl/mem_bus_pkg.sv
rtl/grant_timing_pkg.sv
rtl/grant_timer.sv
rtl/bram_store.sv
rtl/response_stage.sv
rtl/data_mem_port.sv
test/data_mem_port_tb.sv

// ==== rtl/bram_store.sv ====
`timescale 1ns/1ps

module bram_store
   import mem_bus_pkg::*;
(
   input  logic   clk,
   input  logic   i_en,
   input  index_t i_index,
   input  strb_t  i_wstrb,
   input  data_t  i_wdata,
   output data_t  o_rdata
);

   data_t mem [MEM_DEPTH];

   logic is_read;

   // zero strobe on an enabled access means a load
   assign is_read = i_en && (i_wstrb == '0);

   // byte-lane writes
   always_ff @(posedge clk) begin
      if (i_en) begin
         for (int lane = 0; lane < STRB_W; lane++) begin
            if (i_wstrb[lane]) begin
               mem[i_index][lane*LANE_W +: LANE_W] <= i_wdata[lane*LANE_W +: LANE_W];
            end
         end
      end
   end

   // registered read port that holds its value between loads
   always_ff @(posedge clk) begin
      if (is_read) begin
         o_rdata <= mem[i_index];
      end
   end

   // an enabled access must point at a defined word
   index_known: assert property (
      @(posedge clk)
      i_en |-> !$isunknown(i_index)
   );

endmodule

// ==== rtl/data_mem_port.sv ====
`timescale 1ns/1ps

module data_mem_port
   import mem_bus_pkg::*;
(
   input  logic  clk,
   input  logic  reset,

   // core request
   input  logic  i_req,
   input  addr_t i_addr,
   input  logic  i_we,
   input  strb_t i_be,
   input  data_t i_wdata,

   // core response
   output logic  o_gnt,
   output logic  o_rvalid,
   output data_t o_rdata
);

   logic   gnt;
   index_t word_index;
   strb_t  wr_strb;
   data_t  rd_data;

   // word select drops the byte offset bits
   assign word_index = i_addr[ADDR_LSB +: INDEX_W];

   // loads reach the RAM with an all-zero strobe
   assign wr_strb = i_we ? i_be : '0;

   assign o_gnt = gnt;

   grant_timer grant_timer_inst (
      .clk   (clk),
      .reset (reset),
      .i_req (i_req),
      .o_gnt (gnt)
   );

   bram_store bram_store_inst (
      .clk     (clk),
      .i_en    (gnt),
      .i_index (word_index),
      .i_wstrb (wr_strb),
      .i_wdata (i_wdata),
      .o_rdata (rd_data)
   );

   response_stage response_stage_inst (
      .clk      (clk),
      .reset    (reset),
      .i_access (gnt),
      .i_we     (i_we),
      .i_rdata  (rd_data),
      .o_rvalid (o_rvalid),
      .o_rdata  (o_rdata)
   );

   // every grant gets its response two cycles later
   gnt_to_rvalid: assert property (
      @(posedge clk) disable iff (reset)
      gnt |-> ##2 o_rvalid
   );

   rvalid_has_gnt: assert property (
      @(posedge clk) disable iff (reset)
      o_rvalid |-> $past(gnt, 2)
   );

endmodule

// ==== rtl/grant_timer.sv ====
`timescale 1ns/1ps

module grant_timer
   import mem_bus_pkg::*, grant_timing_pkg::*;
(
   input  logic clk,
   input  logic reset,
   input  logic i_req,
   output logic o_gnt
);

   grant_state_t state;
   grant_state_t state_next;

   count_t req_cnt;
   count_t req_cnt_next;
   count_t hold_cnt;
   count_t hold_cnt_next;

   logic req_last;
   logic hold_last;

   // last counted request cycle / last cycle of the hold-off
   assign req_last  = (req_cnt == count_t'(REQ_CYCLES - 1));
   assign hold_last = (hold_cnt == count_t'(HOLD_CYCLES - 1));

   // grant is combinational on the final request cycle
   assign o_gnt = (state == st_count) && i_req && req_last;

   always_comb begin
      state_next    = state;
      req_cnt_next  = req_cnt;
      hold_cnt_next = hold_cnt;

      case (state)
         st_count: begin
            if (o_gnt) begin
               state_next   = st_hold;
               req_cnt_next = '0;
            end else if (i_req) begin
               // count holds while i_req is low
               req_cnt_next = req_cnt + 1'b1;
            end
         end

         st_hold: begin
            // requests are not looked at here
            if (hold_last) begin
               state_next    = st_count;
               hold_cnt_next = '0;
            end else begin
               hold_cnt_next = hold_cnt + 1'b1;
            end
         end

         default: begin
            state_next    = st_count;
            req_cnt_next  = '0;
            hold_cnt_next = '0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= st_count;
         req_cnt  <= '0;
         hold_cnt <= '0;
      end else begin
         state    <= state_next;
         req_cnt  <= req_cnt_next;
         hold_cnt <= hold_cnt_next;
      end
   end

   // a grant opens exactly HOLD_CYCLES cycles of hold-off
   gnt_opens_hold: assert property (
      @(posedge clk) disable iff (reset)
      o_gnt |=> (state == st_hold) [*HOLD_CYCLES] ##1 (state == st_count)
   );

   // grants are always separated by at least one idle cycle
   gnt_single_cycle: assert property (
      @(posedge clk) disable iff (reset)
      o_gnt |=> !o_gnt
   );

endmodule

// ==== rtl/grant_timing_pkg.sv ====
package grant_timing_pkg;

   // request-high cycles needed before a grant
   localparam int REQ_CYCLES = 2;

   // cycles after a grant in which requests are ignored
   localparam int HOLD_CYCLES = 1;

   // counter width for both timer counters
   typedef logic [7:0] count_t;

   // st_count collects request cycles and st_hold is the hold-off window
   typedef enum logic [0:0] {
      st_count,
      st_hold
   } grant_state_t;

endpackage

// ==== rtl/mem_bus_pkg.sv ====
package mem_bus_pkg;

   // core side of the data bus
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = 4;

   // one byte lane per strobe bit
   localparam int LANE_W = DATA_W / STRB_W;

   // on-chip RAM organization
   localparam int MEM_DEPTH = 1024;
   localparam int INDEX_W   = 10;

   // byte address bits below this pick a lane within the word
   localparam int ADDR_LSB = 2;

   // byte address as issued by the core
   typedef logic [ADDR_W-1:0] addr_t;

   // one RAM word and the load/store data width
   typedef logic [DATA_W-1:0] data_t;

   // byte enables with bit n covering data bits n*8 and up
   typedef logic [STRB_W-1:0] strb_t;

   // word index into the RAM array
   typedef logic [INDEX_W-1:0] index_t;

endpackage

// ==== rtl/response_stage.sv ====
`timescale 1ns/1ps

module response_stage
   import mem_bus_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  i_access,
   input  logic  i_we,
   input  data_t i_rdata,
   output logic  o_rvalid,
   output data_t o_rdata
);

   // marks the cycle in which the RAM output belongs to an access
   logic access_q;
   logic we_q;
   logic load_rsp;

   always_ff @(posedge clk) begin
      if (reset) begin
         access_q <= 1'b0;
         we_q     <= 1'b0;
      end else begin
         access_q <= i_access;
         we_q     <= i_we;
      end
   end

   assign load_rsp = access_q && !we_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         o_rvalid <= 1'b0;
      end else begin
         o_rvalid <= access_q;
      end
   end

   // store responses leave the data untouched
   always_ff @(posedge clk) begin
      if (reset) begin
         o_rdata <= '0;
      end else if (load_rsp) begin
         o_rdata <= i_rdata;
      end
   end

   rvalid_single_cycle: assert property (
      @(posedge clk) disable iff (reset)
      o_rvalid |=> !o_rvalid
   );

endmodule

// ==== test/data_mem_port_tests.svh ====
// outputs quiet while nothing is requested
task automatic idle_after_reset();
   for (int cyc = 0; cyc < 6; cyc++) begin
      @(negedge clk);
      check_value("o_gnt", o_gnt, 1'b0);
      check_value("o_rvalid", o_rvalid, 1'b0);
      check_value("o_rdata", o_rdata, '0);
   end
endtask

// request held high across two grants and the hold-off between them
task automatic grant_pacing();
   int    total;
   int    gnt_a;
   int    gnt_b;
   int    latency;
   logic  exp_gnt;
   logic  exp_rvalid;
   data_t wdata;

   wdata = rand_bits(DATA_W);
   gnt_a = REQ_CYCLES;
   gnt_b = 2 * REQ_CYCLES + HOLD_CYCLES;
   total = gnt_b;
   @(posedge clk);
   i_req   <= 1'b1;
   i_addr  <= '0;
   i_we    <= 1'b1;
   i_be    <= '1;
   i_wdata <= wdata;
   for (int cyc = 1; cyc <= total; cyc++) begin
      @(negedge clk);
      exp_gnt    = (cyc == gnt_a) || (cyc == gnt_b);
      exp_rvalid = (cyc == gnt_a + 2);
      check_value("o_gnt", o_gnt, exp_gnt);
      check_value("o_rvalid", o_rvalid, exp_rvalid);
      if (o_gnt) begin
         ref_write('0, '1, wdata);
      end
   end
   @(posedge clk);
   i_req <= 1'b0;
   wait_rvalid(latency);
   if (latency >= 0) begin
      check_value("rvalid latency", latency, 2);
      @(negedge clk);
      check_value("o_rvalid", o_rvalid, 1'b0);
   end
endtask

task automatic write_then_read();
   index_t idx;
   data_t  wdata;
   idx   = index_t'(rand_bits(INDEX_W));
   wdata = rand_bits(DATA_W);
   mem_access(1'b1, word_addr(idx), '1, wdata);
   mem_access(1'b0, word_addr(idx), '0, '0);
   check_value("o_rdata", o_rdata, wdata);
endtask

// old bytes survive where the enable is clear
task automatic partial_write_merge();
   index_t idx;
   data_t  base;
   data_t  patch;
   strb_t  be;
   idx   = index_t'(rand_bits(INDEX_W));
   base  = rand_bits(DATA_W);
   patch = rand_bits(DATA_W);
   be    = strb_t'(rand_bits(STRB_W));
   if (be == '0 || be == '1) begin
      be = 4'b0101;
   end
   mem_access(1'b1, word_addr(idx), '1, base);
   mem_access(1'b1, word_addr(idx), be, patch);
   mem_access(1'b0, word_addr(idx), '0, '0);
   check_value("o_rdata", o_rdata, ref_mem[idx]);
endtask

task automatic write_keeps_rdata();
   index_t idx;
   data_t  first;
   idx   = index_t'(rand_bits(INDEX_W));
   first = rand_bits(DATA_W);
   mem_access(1'b1, word_addr(idx), '1, first);
   mem_access(1'b0, word_addr(idx), '0, '0);
   check_value("o_rdata", o_rdata, first);
   mem_access(1'b1, word_addr(idx), '1, rand_bits(DATA_W));
   check_value("o_rdata", o_rdata, first);
endtask

// loads only hit words that were written whole
task automatic random_traffic();
   index_t written_q[$];
   index_t idx;
   strb_t  be;
   logic   do_write;
   for (int n = 0; n < TRAFFIC_OPS; n++) begin
      do_write = (rand_bits(1) != 0) || (written_q.size() == 0);
      if (do_write) begin
         idx = index_t'(rand_bits(INDEX_W));
         be  = strb_t'(rand_bits(STRB_W));
         if (!ref_valid[idx]) begin
            be = '1;
            written_q.push_back(idx);
         end
         mem_access(1'b1, word_addr(idx), be, rand_bits(DATA_W));
      end else begin
         idx = written_q[rand_bits(8) % written_q.size()];
         mem_access(1'b0, word_addr(idx), '0, '0);
      end
   end
endtask

// ==== test/data_mem_port_tb.sv ====
`timescale 1ns/1ps

module data_mem_port_tb
   import mem_bus_pkg::*, grant_timing_pkg::*;
();

   // cycle limits for the handshake waits
   localparam int GNT_TIMEOUT    = 20;
   localparam int RVALID_TIMEOUT = 10;
   localparam int TRAFFIC_OPS    = 40;

   logic  clk;
   logic  reset;
   logic  i_req;
   addr_t i_addr;
   logic  i_we;
   strb_t i_be;
   data_t i_wdata;
   logic  o_gnt;
   logic  o_rvalid;
   data_t o_rdata;

   int check_count = 0;
   int error_count = 0;

   logic [15:0] lfsr_state = 16'd24;

   // expected RAM contents and the words written as a whole
   data_t ref_mem [MEM_DEPTH];
   bit    ref_valid [MEM_DEPTH];

   // data of the most recent load response
   data_t last_load = '0;

   data_mem_port data_mem_port_inst (
      .clk      (clk),
      .reset    (reset),
      .i_req    (i_req),
      .i_addr   (i_addr),
      .i_we     (i_we),
      .i_be     (i_be),
      .i_wdata  (i_wdata),
      .o_gnt    (o_gnt),
      .o_rvalid (o_rvalid),
      .o_rdata  (o_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      logic fb;
      fb = s[15] ^ s[13] ^ s[12] ^ s[10];
      return {s[14:0], fb};
   endfunction

   // one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic addr_t word_addr(input index_t idx);
      addr_t a;
      a = '0;
      a[ADDR_LSB +: INDEX_W] = idx;
      return a;
   endfunction

   function automatic void ref_write(input index_t idx, input strb_t be, input data_t wdata);
      for (int lane = 0; lane < STRB_W; lane++) begin
         if (be[lane]) begin
            ref_mem[idx][lane*8 +: 8] = wdata[lane*8 +: 8];
         end
      end
      if (be == '1) begin
         ref_valid[idx] = 1'b1;
      end
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      check_count++;
      if (got !== exp) begin
         $display("** Error: %s is 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
         error_count++;
      end
   endtask

   // counts negedges until o_rvalid and gives -1 on timeout
   task automatic wait_rvalid(output int latency);
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < RVALID_TIMEOUT) begin
         @(negedge clk);
         cycles++;
         seen = o_rvalid;
      end
      if (seen) begin
         latency = cycles;
      end else begin
         $display("o_rvalid did not rise within %0d cycles of the grant", RVALID_TIMEOUT);
         error_count++;
         latency = -1;
      end
   endtask

   // one full request, grant and response
   task automatic mem_access(input logic we, input addr_t addr, input strb_t be,
                             input data_t wdata);
      int     waited;
      int     latency;
      logic   granted;
      index_t idx;
      data_t  exp_rdata;

      idx     = addr[ADDR_LSB +: INDEX_W];
      granted = 1'b0;
      waited  = 0;
      @(posedge clk);
      i_req   <= 1'b1;
      i_addr  <= addr;
      i_we    <= we;
      i_be    <= be;
      i_wdata <= wdata;
      while (!granted && waited < GNT_TIMEOUT) begin
         @(negedge clk);
         waited++;
         granted = o_gnt;
      end
      if (!granted) begin
         $display("no grant within %0d cycles for the request to 0x%08h", GNT_TIMEOUT, addr);
         error_count++;
         @(posedge clk);
         i_req <= 1'b0;
         return;
      end
      // a load returns the word as it stood before this cycle
      if (we) begin
         exp_rdata = last_load;
         ref_write(idx, be, wdata);
      end else begin
         exp_rdata = ref_mem[idx];
         last_load = exp_rdata;
      end
      @(posedge clk);
      i_req <= 1'b0;
      wait_rvalid(latency);
      if (latency >= 0) begin
         check_value("rvalid latency", latency, 2);
         check_value("o_rdata", o_rdata, exp_rdata);
         @(negedge clk);
         check_value("o_rvalid", o_rvalid, 1'b0);
      end
   endtask

   `include "data_mem_port_tests.svh"

   initial begin
      reset   <= 1'b1;
      i_req   <= 1'b0;
      i_addr  <= '0;
      i_we    <= 1'b0;
      i_be    <= '0;
      i_wdata <= '0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;

      idle_after_reset();
      grant_pacing();
      write_then_read();
      partial_write_merge();
      write_keeps_rdata();
      random_traffic();

      $display("checks run: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule
